//--- include/frontEndVectors.svh
`ifndef FRONT_END_VECTORS_SVH
`define FRONT_END_VECTORS_SVH

// one row per clock after reset
typedef struct packed {
    logic [15:0] fetchInst;
    logic        redirValid;
    logic [15:0] redirTarget;
    logic        expStall;
    logic [15:0] expPc;
    logic [15:0] expDec;
} vecRowT;

localparam int NUM_ROWS = 31;

// columns: fetchInst, redirect valid, redirect target,
// stall this cycle, pc after the edge, decInst after the edge
localparam vecRowT VECTORS [NUM_ROWS] = '{
    // nop from reset, then independent add / ld / st / addi / lbi / add
    '{16'h0800, 1'b0, 16'h0000, 1'b0, 16'h0002, 16'h0800},
    '{16'hD94C, 1'b0, 16'h0000, 1'b0, 16'h0004, 16'hD94C},
    '{16'h8CA0, 1'b0, 16'h0000, 1'b0, 16'h0006, 16'h8CA0},
    '{16'h8640, 1'b0, 16'h0000, 1'b0, 16'h0008, 16'h8640},
    '{16'h40C1, 1'b0, 16'h0000, 1'b0, 16'h000A, 16'h40C1},
    '{16'hC455, 1'b0, 16'h0000, 1'b0, 16'h000C, 16'hC455},
    '{16'hD8E4, 1'b0, 16'h0000, 1'b0, 16'h000E, 16'hD8E4},
    // st reads r1 as rd, add to r1 still in dec..wb
    '{16'h8020, 1'b0, 16'h0000, 1'b1, 16'h000E, 16'h0800},
    '{16'h8020, 1'b0, 16'h0000, 1'b1, 16'h000E, 16'h0800},
    '{16'h8020, 1'b0, 16'h0000, 1'b1, 16'h000E, 16'h0800},
    '{16'h8020, 1'b0, 16'h0000, 1'b1, 16'h000E, 16'h0800},
    '{16'h8020, 1'b0, 16'h0000, 1'b0, 16'h0010, 16'h8020},
    // add to r2, then lbi with r2 only in bits 7:5
    '{16'hD808, 1'b0, 16'h0000, 1'b0, 16'h0012, 16'hD808},
    '{16'hC340, 1'b0, 16'h0000, 1'b0, 16'h0014, 16'hC340},
    // branch issues at once, two bubbles, resolved as not taken
    '{16'h6504, 1'b0, 16'h0000, 1'b1, 16'h0014, 16'h6504},
    '{16'h6504, 1'b0, 16'h0000, 1'b1, 16'h0014, 16'h0800},
    '{16'h6504, 1'b1, 16'h0016, 1'b1, 16'h0016, 16'h0800},
    '{16'hDEF0, 1'b0, 16'h0000, 1'b0, 16'h0018, 16'hDEF0},
    // redirect squashes the ld
    '{16'h88C0, 1'b1, 16'h0040, 1'b0, 16'h0040, 16'h0800},
    '{16'h42A3, 1'b0, 16'h0000, 1'b0, 16'h0042, 16'h42A3},
    // halt passes through, pc frozen until a redirect
    '{16'h0000, 1'b0, 16'h0000, 1'b1, 16'h0042, 16'h0000},
    '{16'h0000, 1'b0, 16'h0000, 1'b1, 16'h0042, 16'h0000},
    '{16'h0000, 1'b0, 16'h0000, 1'b1, 16'h0042, 16'h0000},
    '{16'h0000, 1'b1, 16'h0080, 1'b1, 16'h0080, 16'h0800},
    // jal links r7, jr r7 waits four cycles
    '{16'h3004, 1'b0, 16'h0000, 1'b0, 16'h0082, 16'h3004},
    '{16'h2F00, 1'b0, 16'h0000, 1'b1, 16'h0082, 16'h0800},
    '{16'h2F00, 1'b0, 16'h0000, 1'b1, 16'h0082, 16'h0800},
    '{16'h2F00, 1'b0, 16'h0000, 1'b1, 16'h0082, 16'h0800},
    '{16'h2F00, 1'b0, 16'h0000, 1'b1, 16'h0082, 16'h0800},
    '{16'h2F00, 1'b0, 16'h0000, 1'b0, 16'h0084, 16'h2F00},
    '{16'h0800, 1'b0, 16'h0000, 1'b0, 16'h0086, 16'h0800}
};

`endif

//--- dv/frontEndTb.sv
`timescale 1ns/100ps

module frontEndTb;

    `include "frontEndVectors.svh"

    localparam int RESET_CYCLES = 16;
    // rows plus reset plus some slack
    localparam int CYCLE_LIMIT  = NUM_ROWS + RESET_CYCLES + 20;

    logic                  clk;
    logic                  arstN;
    frontEndPkg::instT     fetchInst;
    frontEndPkg::redirectT redirect;
    frontEndPkg::pcT       pc;
    frontEndPkg::instT     decInst;
    logic                  stall;

    int errorCount;
    int cycleCount;

    frontEnd DUT (
        .clk       (clk),
        .arstN     (arstN),
        .fetchInst (fetchInst),
        .redirect  (redirect),
        .pc        (pc),
        .decInst   (decInst),
        .stall     (stall)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // flag a mismatch and count it
    task automatic compareValue(
        input string       name,
        input logic [15:0] actual,
        input logic [15:0] expected
    );
        if (actual !== expected) begin
            errorCount++;
            $display("Error: %s is 0x%h, expected 0x%h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // runaway guard
    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: test did not finish within %0d cycles, %0d errors so far",
                 CYCLE_LIMIT, errorCount);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        errorCount     = 0;
        arstN          = 1'b0;
        fetchInst      = frontEndPkg::NOP_INST;
        redirect       = '0;

        // reset held for 16 cycles and released just after an edge
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN = 1'b1;

        // reset values straight out of reset
        compareValue("pc after reset", pc, 16'h0000);
        compareValue("decInst after reset", decInst, 16'h0800);

        for (int i = 0; i < NUM_ROWS; i++) begin
            // drive 1 ns after the edge
            fetchInst       = VECTORS[i].fetchInst;
            redirect.valid  = VECTORS[i].redirValid;
            redirect.target = VECTORS[i].redirTarget;

            // stall is combinational and settled by mid cycle
            @(negedge clk);
            compareValue($sformatf("stall row %0d", i),
                         {15'd0, stall}, {15'd0, VECTORS[i].expStall});

            // registered outputs after the edge
            @(posedge clk);
            #1;
            compareValue($sformatf("pc row %0d", i), pc, VECTORS[i].expPc);
            compareValue($sformatf("decInst row %0d", i), decInst, VECTORS[i].expDec);
        end

        // idle the bus
        fetchInst = frontEndPkg::NOP_INST;
        redirect  = '0;

        $display("%0d rows applied, %0d errors", NUM_ROWS, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
rtl/frontEndPkg.sv
rtl/hazardDetect.sv
rtl/instDecode.sv
rtl/stageTracker.sv
rtl/pcUnit.sv
rtl/frontEnd.sv
dv/frontEndTb.sv

//--- rtl/frontEnd.sv
`timescale 1ns/100ps

module frontEnd (
    input  logic                  clk,
    input  logic                  arstN,
    input  frontEndPkg::instT     fetchInst,
    input  frontEndPkg::redirectT redirect,
    output frontEndPkg::pcT       pc,
    output frontEndPkg::instT     decInst,
    output logic                  stall
);

    // hazard select -> decode register
    frontEndPkg::instT      issueInst;
    // write / branch info of the issued word
    frontEndPkg::stageInfoT issueInfo;
    // dec / exe / mem / wb info back to hazard check
    frontEndPkg::inFlightT  inFlight;

    hazardDetect uHazardDetect (
        .fetchInst     (fetchInst),
        .inFlight      (inFlight),
        .redirectValid (redirect.valid),
        .issueInst     (issueInst),
        .stall         (stall)
    );

    instDecode uInstDecode (
        .inst (issueInst),
        .info (issueInfo)
    );

    stageTracker uStageTracker (
        .clk       (clk),
        .arstN     (arstN),
        .issueInst (issueInst),
        .issueInfo (issueInfo),
        .decInst   (decInst),
        .inFlight  (inFlight)
    );

    // pc hold / step / redirect
    pcUnit uPcUnit (
        .clk      (clk),
        .arstN    (arstN),
        .stall    (stall),
        .redirect (redirect),
        .pc       (pc)
    );

endmodule

//--- rtl/frontEndPkg.sv
package frontEndPkg;

    // widths that carry a meaning
    typedef logic [15:0] instT;
    typedef logic [15:0] pcT;
    typedef logic [2:0]  regIdxT;
    typedef logic [4:0]  opcodeT;

    // bubble word, opcode 00001 and nothing else
    localparam instT NOP_INST = 16'b00001_000_0000_0000;

    // one instruction is two bytes
    localparam pcT PC_STEP = 16'd2;
    localparam pcT RST_PC  = 16'd0;

    // full major opcodes
    localparam opcodeT OP_HALT  = 5'b00000;
    localparam opcodeT OP_ST    = 5'b10000;
    localparam opcodeT OP_STU   = 5'b10011;
    localparam opcodeT OP_LD    = 5'b10001;
    localparam opcodeT OP_ARITH = 5'b11011;
    localparam opcodeT OP_BITOP = 5'b11010;
    localparam opcodeT OP_LBI   = 5'b11000;
    localparam opcodeT OP_SLBI  = 5'b10010;
    localparam opcodeT OP_BTR   = 5'b11001;

    // class prefixes, opcode bits 4:2
    // 000xx covers halt, nop, siic and rti
    localparam logic [2:0] OP_NOP_PFX  = 3'b000;
    localparam logic [2:0] OP_SET_PFX  = 3'b111;
    localparam logic [2:0] OP_BR_PFX   = 3'b011;
    localparam logic [2:0] OP_JMP_PFX  = 3'b001;
    // immediate alu forms, rd in bits 7:5
    localparam logic [2:0] OP_ALUI_PFX = 3'b010;
    localparam logic [2:0] OP_SHFI_PFX = 3'b101;

    // link register for jal / jalr
    localparam regIdxT REG_LINK = 3'd7;

    // write / branch info for one pipe stage
    typedef struct packed {
        logic   regWrt;
        regIdxT wrtReg;
        logic   isBranch;
    } stageInfoT;

    // everything past fetch, youngest first
    typedef struct packed {
        stageInfoT dec;
        stageInfoT exe;
        stageInfoT mem;
        stageInfoT wb;
    } inFlightT;

    // from branch resolution
    typedef struct packed {
        logic valid;
        pcT   target;
    } redirectT;

endpackage

//--- rtl/hazardDetect.sv
`timescale 1ns/100ps

module hazardDetect (
    input  frontEndPkg::instT     fetchInst,
    input  frontEndPkg::inFlightT inFlight,
    input  logic                  redirectValid,
    output frontEndPkg::instT     issueInst,
    output logic                  stall
);

    // register fields of the fetched word
    frontEndPkg::opcodeT opcode;
    frontEndPkg::regIdxT srcRs;
    frontEndPkg::regIdxT srcRt;

    // which fields the opcode class reads
    logic useRs;
    logic useRt;

    // fetch-side class flags
    logic isHalt;
    logic passClass;
    logic branchInFetch;

    // compare results
    logic rsHit;
    logic rtHit;
    logic dataHit;
    logic branchInFlight;

    // raw compare of one source against every writer still in the pipe
    function automatic logic regHit(
        input frontEndPkg::regIdxT  src,
        input frontEndPkg::inFlightT fl
    );
        return (fl.dec.regWrt && (fl.dec.wrtReg == src)) ||
               (fl.exe.regWrt && (fl.exe.wrtReg == src)) ||
               (fl.mem.regWrt && (fl.mem.wrtReg == src)) ||
               (fl.wb.regWrt  && (fl.wb.wrtReg  == src));
    endfunction

    assign opcode = fetchInst[15:11];
    assign srcRs  = fetchInst[10:8];
    // bits 7:5 are rd for stores, rt for alu classes
    assign srcRt  = fetchInst[7:5];

    // each field compared once, the class decides if it counts
    assign rsHit = regHit(srcRs, inFlight);
    assign rtHit = regHit(srcRt, inFlight);

    // source-use pattern per opcode class
    always_comb begin
        useRs         = 1'b0;
        useRt         = 1'b0;
        isHalt        = 1'b0;
        passClass     = 1'b0;
        branchInFetch = 1'b0;
        if (opcode == frontEndPkg::OP_HALT) begin
            isHalt    = 1'b1;
            passClass = 1'b1;
        end else if (opcode[4:2] == frontEndPkg::OP_NOP_PFX) begin
            // nop, siic, rti read nothing
            passClass = 1'b1;
        end else if (opcode == frontEndPkg::OP_ST || opcode == frontEndPkg::OP_STU) begin
            // stores read base and data
            useRs = 1'b1;
            useRt = 1'b1;
        end else if (opcode == frontEndPkg::OP_ARITH ||
                     opcode == frontEndPkg::OP_BITOP ||
                     opcode[4:2] == frontEndPkg::OP_SET_PFX) begin
            useRs = 1'b1;
            useRt = 1'b1;
        end else if (opcode[4:2] == frontEndPkg::OP_BR_PFX) begin
            branchInFetch = 1'b1;
            useRs         = 1'b1;
        end else begin
            // default class incl. jumps, rs only
            useRs = 1'b1;
        end
    end

    assign dataHit        = (useRs && rsHit) || (useRt && rtHit);
    assign branchInFlight = inFlight.dec.isBranch || inFlight.exe.isBranch;

    // hold pc on raw hit, branch shadow, fetched branch or halt
    assign stall = dataHit || branchInFlight || branchInFetch || isHalt;

    // issue selection
    always_comb begin
        if (redirectValid) begin
            // squash wrong-path word
            issueInst = frontEndPkg::NOP_INST;
        end else if (passClass || (branchInFetch && !branchInFlight)) begin
            // halt / nop class and a fresh branch enter decode even when stalled
            // a branch seen again in the shadow of the last one is held back
            issueInst = fetchInst;
        end else if (stall) begin
            issueInst = frontEndPkg::NOP_INST;
        end else begin
            issueInst = fetchInst;
        end
    end

    // only one branch in dec / exe at a time
    always_comb begin
        assert (!(branchInFlight && issueInst[15:13] == frontEndPkg::OP_BR_PFX))
            else $error("branch issued while another branch is in dec or exe");
    end

endmodule

//--- rtl/instDecode.sv
`timescale 1ns/100ps

module instDecode (
    input  frontEndPkg::instT      inst,
    output frontEndPkg::stageInfoT info
);

    frontEndPkg::opcodeT opcode;
    logic [2:0]          opPfx;

    assign opcode = inst[15:11];
    assign opPfx  = inst[15:13];

    // destination select per opcode class
    always_comb begin
        info.regWrt   = 1'b0;
        info.wrtReg   = '0;
        info.isBranch = 1'b0;

        if (opcode == frontEndPkg::OP_ARITH ||
            opcode == frontEndPkg::OP_BITOP ||
            opcode == frontEndPkg::OP_BTR   ||
            opPfx  == frontEndPkg::OP_SET_PFX) begin
            // three-register forms, rd in bits 4:2
            info.regWrt = 1'b1;
            info.wrtReg = inst[4:2];
        end else if (opcode == frontEndPkg::OP_LD    ||
                     opPfx  == frontEndPkg::OP_ALUI_PFX ||
                     opPfx  == frontEndPkg::OP_SHFI_PFX) begin
            // load and immediate alu, rd in bits 7:5
            info.regWrt = 1'b1;
            info.wrtReg = inst[7:5];
        end else if (opcode == frontEndPkg::OP_STU ||
                     opcode == frontEndPkg::OP_LBI ||
                     opcode == frontEndPkg::OP_SLBI) begin
            // stu writes back the base, lbi / slbi target rs
            info.regWrt = 1'b1;
            info.wrtReg = inst[10:8];
        end else if (opPfx == frontEndPkg::OP_JMP_PFX && opcode[1]) begin
            // jal / jalr link into r7
            info.regWrt = 1'b1;
            info.wrtReg = frontEndPkg::REG_LINK;
        end

        // branch class for the fetch freeze
        info.isBranch = (opPfx == frontEndPkg::OP_BR_PFX);
    end

endmodule

//--- rtl/pcUnit.sv
`timescale 1ns/100ps

module pcUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  frontEndPkg::redirectT redirect,
    output frontEndPkg::pcT       pc
);

    frontEndPkg::pcT pcNext;

    // redirect beats stall beats increment
    always_comb begin
        if (redirect.valid) begin
            pcNext = redirect.target;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + frontEndPkg::PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= frontEndPkg::RST_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // stall from hazard logic freezes fetch
    assert property (@(posedge clk) disable iff (!arstN)
        (stall && !redirect.valid) |=> $stable(pc))
        else $error("pc moved during stall");

endmodule

//--- rtl/stageTracker.sv
`timescale 1ns/100ps

module stageTracker (
    input  logic                   clk,
    input  logic                   arstN,
    input  frontEndPkg::instT      issueInst,
    input  frontEndPkg::stageInfoT issueInfo,
    output frontEndPkg::instT      decInst,
    output frontEndPkg::inFlightT  inFlight
);

    // decode instruction register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // come out of reset with a bubble in decode
            decInst <= frontEndPkg::NOP_INST;
        end else begin
            decInst <= issueInst;
        end
    end

    // write / branch info marches dec -> exe -> mem -> wb
    // no enable, bubbles carry zero info
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inFlight <= '0;
        end else begin
            inFlight.dec <= issueInfo;
            inFlight.exe <= inFlight.dec;
            inFlight.mem <= inFlight.exe;
            inFlight.wb  <= inFlight.mem;
        end
    end

    // bubble in decode must not look like a writer
    assert property (@(posedge clk) disable iff (!arstN)
        (decInst == frontEndPkg::NOP_INST) |-> !inFlight.dec.regWrt)
        else $error("nop in decode flagged as register write");

endmodule

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f filelist.f \
    --top-module frontEndTb \
    -o frontEndSim

./obj_dir/frontEndSim > sim.log 2>&1

cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
